// ==== logic/axi_sram_pkg.sv ====
/*
 * Shared widths, burst encodings and the beat address rule for the AXI4 SRAM slave.
 * Both burst engines import this package and compute beat addresses through it.
 */
package axi_sram_pkg;

  // bus and memory geometry
  localparam int ADDR_W       = 16;
  localparam int DATA_W       = 32;
  localparam int STRB_W       = DATA_W / 8;
  localparam int ID_W         = 4;
  localparam int LEN_W        = 8;
  localparam int MEM_WORDS    = 1024;
  localparam int MEM_AW       = $clog2(MEM_WORDS);
  localparam int LOG_NR_BYTES = $clog2(STRB_W);

  // AXI burst type field
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // byte address of beat idx within a burst
  // WRAP assumes len+1 of 2, 4, 8 or 16
  function automatic logic [ADDR_W-1:0] beat_addr(
    input logic [ADDR_W-1:0] start,
    input logic [LEN_W-1:0]  len,
    input axi_burst_e        burst,
    input logic [LEN_W-1:0]  idx
  );
    logic [ADDR_W-1:0] aligned;
    logic [ADDR_W-1:0] wrap_size;
    logic [ADDR_W-1:0] wrap_low;
    logic [ADDR_W-1:0] next;
    aligned   = {start[ADDR_W-1:LOG_NR_BYTES], {LOG_NR_BYTES{1'b0}}};
    wrap_size = (ADDR_W'(len) + 1'b1) << LOG_NR_BYTES;
    wrap_low  = aligned & ~(wrap_size - 1'b1);
    next      = aligned + (ADDR_W'(idx) << LOG_NR_BYTES);
    case (burst)
      FIXED:   return start;
      // one subtraction is enough since idx never exceeds len
      WRAP:    return (next >= wrap_low + wrap_size) ? next - wrap_size : next;
      default: return next;
    endcase
  endfunction

endpackage

// ==== logic/mem_port_if.sv ====
/*
 * One SRAM access port between a burst engine and the memory port arbiter.
 * The engine holds req and its fields until gnt, read data follows one cycle later.
 */
`timescale 1ns/1ps

interface mem_port_if import axi_sram_pkg::*; ();

  // request side, driven by the engine
  logic              req;
  logic              we;
  logic [MEM_AW-1:0] addr;
  logic [STRB_W-1:0] be;
  logic [DATA_W-1:0] wdata;

  // answer side, driven by the arbiter
  logic              gnt;
  logic [DATA_W-1:0] rdata;

  modport engine  (output req, we, addr, be, wdata, input gnt, rdata);
  modport arbiter (input req, we, addr, be, wdata, output gnt, rdata);

endinterface

// ==== logic/sp_sram.sv ====
/*
 * Single-port SRAM model with byte enables.
 * Writes are byte masked, reads return data one cycle after the enable.
 */
`timescale 1ns/1ps

module sp_sram import axi_sram_pkg::*; (
  input  logic              clk_i,
  input  logic              en_i,
  input  logic              we_i,
  input  logic [MEM_AW-1:0] addr_i,
  input  logic [STRB_W-1:0] be_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        // merge only the enabled byte lanes
        for (int i = 0; i < STRB_W; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        // registered read
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== logic/mem_port_arbiter.sv ====
/*
 * Round-robin arbiter that merges the read and write engine ports onto one SRAM port
 * and steers returned read data back to the port that issued the read.
 */
`timescale 1ns/1ps

module mem_port_arbiter import axi_sram_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  mem_port_if.arbiter       rd_port,
  mem_port_if.arbiter       wr_port,
  // single SRAM port
  output logic              sram_en_o,
  output logic              sram_we_o,
  output logic [MEM_AW-1:0] sram_addr_o,
  output logic [STRB_W-1:0] sram_be_o,
  output logic [DATA_W-1:0] sram_wdata_o,
  input  logic [DATA_W-1:0] sram_rdata_i
);

  // set when the write port wins the next tie
  logic prio_wr_q;
  logic gnt_rd;
  logic gnt_wr;
  // read in flight, tagged with its owner
  logic rd_own_q;
  logic wr_own_q;

  // grant in the same cycle as the request
  assign gnt_rd = rd_port.req && (!wr_port.req || !prio_wr_q);
  assign gnt_wr = wr_port.req && (!rd_port.req || prio_wr_q);

  assign rd_port.gnt = gnt_rd;
  assign wr_port.gnt = gnt_wr;

  // winner's fields go to the SRAM
  assign sram_en_o    = gnt_rd || gnt_wr;
  assign sram_we_o    = gnt_wr ? wr_port.we    : rd_port.we;
  assign sram_addr_o  = gnt_wr ? wr_port.addr  : rd_port.addr;
  assign sram_be_o    = gnt_wr ? wr_port.be    : rd_port.be;
  assign sram_wdata_o = gnt_wr ? wr_port.wdata : rd_port.wdata;

  // only the owner of the read sees the word
  assign rd_port.rdata = rd_own_q ? sram_rdata_i : '0;
  assign wr_port.rdata = wr_own_q ? sram_rdata_i : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_wr_q <= 1'b0;
      rd_own_q  <= 1'b0;
      wr_own_q  <= 1'b0;
    end else begin
      // the port just served drops to the back
      if (gnt_rd) prio_wr_q <= 1'b1;
      else if (gnt_wr) prio_wr_q <= 1'b0;
      rd_own_q <= gnt_rd && !rd_port.we;
      wr_own_q <= gnt_wr && !wr_port.we;
    end
  end

endmodule

// ==== logic/axi_rd_engine.sv ====
/*
 * AXI4 read engine. Accepts one AR burst at a time, fetches one SRAM word per beat
 * and returns it on R, holding R stable while the master applies back-pressure.
 */
`timescale 1ns/1ps

module axi_rd_engine import axi_sram_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // read address channel
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [LEN_W-1:0]  ar_len_i,
  input  logic [1:0]        ar_burst_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  // read data channel
  output logic [ID_W-1:0]   r_id_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  // SRAM access port
  mem_port_if.engine        mem
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    RESP
  } rd_state_e;

  rd_state_e         state_q;
  logic [LEN_W-1:0]  cnt_q;
  // high in the cycle the granted word arrives
  logic              capture_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  axi_burst_e        burst_q;
  logic [DATA_W-1:0] r_data_q;
  logic [ADDR_W-1:0] cur_addr;
  logic              ar_hs;

  // accept a new burst only while idle
  assign ar_ready_o = (state_q == IDLE) && ar_valid_i;
  assign ar_hs      = ar_ready_o;

  ////////////////////////////////////////////////////////////////////
  // memory request
  ////////////////////////////////////////////////////////////////////

  assign cur_addr  = beat_addr(addr_q, len_q, burst_q, cnt_q);
  assign mem.req   = (state_q == FETCH);
  assign mem.we    = 1'b0;
  assign mem.addr  = cur_addr[LOG_NR_BYTES +: MEM_AW];
  assign mem.be    = '0;
  assign mem.wdata = '0;

  ////////////////////////////////////////////////////////////////////
  // read response
  ////////////////////////////////////////////////////////////////////

  // fresh word goes straight out, later cycles replay the held copy
  assign r_data_o  = capture_q ? mem.rdata : r_data_q;
  assign r_valid_o = (state_q == RESP);
  assign r_last_o  = (state_q == RESP) && (cnt_q == len_q);
  assign r_id_o    = id_q;
  assign r_resp_o  = RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      capture_q <= 1'b0;
    end else begin
      capture_q <= (state_q == FETCH) && mem.gnt;
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            cnt_q   <= '0;
            state_q <= FETCH;
          end
        end
        FETCH: begin
          // data shows up the cycle after the grant
          if (mem.gnt) state_q <= RESP;
        end
        RESP: begin
          if (r_ready_i) begin
            if (r_last_o) begin
              state_q <= IDLE;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= FETCH;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // burst attributes and held read word
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      len_q   <= ar_len_i;
      burst_q <= axi_burst_e'(ar_burst_i);
    end
    if (capture_q) r_data_q <= mem.rdata;
  end

endmodule

// ==== logic/axi_wr_engine.sv ====
/*
 * AXI4 write engine. Accepts one AW burst, writes each W beat to the SRAM with its
 * byte strobes in the cycle it is accepted, and answers with a single B response.
 */
`timescale 1ns/1ps

module axi_wr_engine import axi_sram_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // write address channel
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  input  logic [1:0]        aw_burst_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  // write data channel
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  // write response channel
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  // SRAM access port
  mem_port_if.engine        mem
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    SEND_B
  } wr_state_e;

  wr_state_e         state_q;
  logic [LEN_W-1:0]  cnt_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  axi_burst_e        burst_q;
  logic [ADDR_W-1:0] cur_addr;
  logic              aw_hs;
  logic              w_hs;

  // new burst only while idle
  assign aw_ready_o = (state_q == IDLE) && aw_valid_i;
  assign aw_hs      = aw_ready_o;

  ////////////////////////////////////////////////////////////////////
  // beat write path
  ////////////////////////////////////////////////////////////////////

  assign cur_addr = beat_addr(addr_q, len_q, burst_q, cnt_q);

  // a pending W beat is the request itself
  // AXI keeps w_valid and its payload stable until accepted
  assign mem.req   = (state_q == WRITE) && w_valid_i;
  assign mem.we    = 1'b1;
  assign mem.addr  = cur_addr[LOG_NR_BYTES +: MEM_AW];
  assign mem.be    = w_strb_i;
  assign mem.wdata = w_data_i;

  // beat is accepted in the very cycle the SRAM takes it
  assign w_ready_o = (state_q == WRITE) && mem.gnt;
  assign w_hs      = w_ready_o && w_valid_i;

  ////////////////////////////////////////////////////////////////////
  // write response
  ////////////////////////////////////////////////////////////////////

  assign b_valid_o = (state_q == SEND_B);
  assign b_id_o    = id_q;
  assign b_resp_o  = RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (aw_hs) begin
            cnt_q   <= '0;
            state_q <= WRITE;
          end
        end
        WRITE: begin
          if (w_hs) begin
            cnt_q <= cnt_q + 1'b1;
            // burst ends on w_last, the beat count only steers the address
            if (w_last_i) state_q <= SEND_B;
          end
        end
        SEND_B: begin
          if (b_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // burst attributes
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q    <= aw_id_i;
      addr_q  <= aw_addr_i;
      len_q   <= aw_len_i;
      burst_q <= axi_burst_e'(aw_burst_i);
    end
  end

endmodule

// ==== logic/axi_sram_top.sv ====
/*
 * AXI4 slave in front of a single-port SRAM.
 * Read and write engines run side by side and share the SRAM through an arbiter.
 */
`timescale 1ns/1ps

module axi_sram_top import axi_sram_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // AW
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  input  logic [1:0]        aw_burst_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  // W
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  // B
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  // AR
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [LEN_W-1:0]  ar_len_i,
  input  logic [1:0]        ar_burst_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  // R
  output logic [ID_W-1:0]   r_id_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  output logic              r_valid_o,
  input  logic              r_ready_i
);

  ////////////////////////////////////////////////////////////////////
  // engine ports and SRAM wires
  ////////////////////////////////////////////////////////////////////

  mem_port_if rd_mem ();
  mem_port_if wr_mem ();

  logic              sram_en;
  logic              sram_we;
  logic [MEM_AW-1:0] sram_addr;
  logic [STRB_W-1:0] sram_be;
  logic [DATA_W-1:0] sram_wdata;
  logic [DATA_W-1:0] sram_rdata;

  axi_rd_engine u_rd_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .ar_burst_i (ar_burst_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .mem        (rd_mem)
  );

  axi_wr_engine u_wr_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .aw_burst_i (aw_burst_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .mem        (wr_mem)
  );

  mem_port_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_port      (rd_mem),
    .wr_port      (wr_mem),
    .sram_en_o    (sram_en),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_be_o    (sram_be),
    .sram_wdata_o (sram_wdata),
    .sram_rdata_i (sram_rdata)
  );

  sp_sram u_sram (
    .clk_i   (clk_i),
    .en_i    (sram_en),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .be_i    (sram_be),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

endmodule

// ==== dv/tb_axi_sram.sv ====
/*
 * Testbench for the AXI4 SRAM slave. Drives bursts of every type through the plain AXI
 * ports, keeps a byte-exact model memory and checks every R beat and B response.
 */
`timescale 1ns/1ps

module tb_axi_sram import axi_sram_pkg::*; ();

  logic              clk_i;
  logic              rst_ni;
  logic [ID_W-1:0]   aw_id_i;
  logic [ADDR_W-1:0] aw_addr_i;
  logic [LEN_W-1:0]  aw_len_i;
  logic [1:0]        aw_burst_i;
  logic              aw_valid_i;
  logic              aw_ready_o;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              w_last_i;
  logic              w_valid_i;
  logic              w_ready_o;
  logic [ID_W-1:0]   b_id_o;
  logic [1:0]        b_resp_o;
  logic              b_valid_o;
  logic              b_ready_i;
  logic [ID_W-1:0]   ar_id_i;
  logic [ADDR_W-1:0] ar_addr_i;
  logic [LEN_W-1:0]  ar_len_i;
  logic [1:0]        ar_burst_i;
  logic              ar_valid_i;
  logic              ar_ready_o;
  logic [ID_W-1:0]   r_id_o;
  logic [DATA_W-1:0] r_data_o;
  logic [1:0]        r_resp_o;
  logic              r_last_o;
  logic              r_valid_o;
  logic              r_ready_i;

  // model memory and the beats of the next write burst
  logic [DATA_W-1:0] model_mem [MEM_WORDS];
  logic [DATA_W-1:0] wdata_buf [16];
  logic [STRB_W-1:0] wstrb_buf [16];

  // expected responses, oldest first
  logic [DATA_W-1:0] exp_r_data [$];
  logic              exp_r_last [$];
  logic [ID_W-1:0]   exp_r_id [$];
  logic [ID_W-1:0]   exp_b_id [$];

  int   data_errs = 0;
  int   proto_errs = 0;
  int   max_wait = 400;
  // random low phases on r_ready and b_ready
  logic bp_en = 1'b0;

  axi_sram_top u_axi_sram_top (.*);

  ////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////

  // byte address of one beat, FIXED 00, INCR 01, WRAP 10
  function automatic logic [ADDR_W-1:0] ref_beat_addr(input logic [ADDR_W-1:0] start,
                                                      input logic [31:0] len,
                                                      input logic [1:0] burst,
                                                      input logic [31:0] idx);
    logic [31:0] base;
    logic [31:0] size;
    logic [31:0] low;
    logic [31:0] addr;
    base = 32'(start) & ~(32'(STRB_W) - 32'd1);
    addr = base + idx * 32'(STRB_W);
    if (burst == 2'b00) begin
      addr = 32'(start);
    end else if (burst == 2'b10) begin
      // window of len+1 words, aligned to its own size
      size = (len + 32'd1) * 32'(STRB_W);
      low  = base - (base % size);
      if (addr >= low + size) addr = addr - size;
    end
    return addr[ADDR_W-1:0];
  endfunction

  function automatic int word_index(input logic [ADDR_W-1:0] addr);
    return (int'(addr) / STRB_W) % MEM_WORDS;
  endfunction

  // initial content, unique per word
  function automatic logic [DATA_W-1:0] fill_pattern(input int word);
    return 32'hc300_0000 | (32'(word) * 32'h0001_0001);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////

  task automatic timeout_abort(input string what);
    $display("timeout at %0t: no %s within %0d cycles", $time, what, max_wait);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic load_random_beats(input int len, input logic partial);
    int k;
    for (k = 0; k <= len; k++) begin
      wdata_buf[k] = $urandom();
      if (partial) wstrb_buf[k] = STRB_W'($urandom_range(1, (1 << STRB_W) - 1));
      else wstrb_buf[k] = '1;
    end
  endtask

  // AW, then the W beats from the buffers, then wait for B
  task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input int len, input logic [1:0] burst);
    int waited;
    int beat;
    int word;
    int b;
    aw_id_i    <= id;
    aw_addr_i  <= addr;
    aw_len_i   <= LEN_W'(len);
    aw_burst_i <= burst;
    aw_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > max_wait) timeout_abort("AW handshake");
    end while (!aw_ready_o);
    aw_valid_i <= 1'b0;
    exp_b_id.push_back(id);
    for (beat = 0; beat <= len; beat++) begin
      w_data_i  <= wdata_buf[beat];
      w_strb_i  <= wstrb_buf[beat];
      w_last_i  <= (beat == len);
      w_valid_i <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
        if (waited > max_wait) timeout_abort("W handshake");
      end while (!w_ready_o);
      // merge the accepted beat byte by byte
      word = word_index(ref_beat_addr(addr, len, burst, beat));
      for (b = 0; b < STRB_W; b++) begin
        if (wstrb_buf[beat][b]) model_mem[word][8*b +: 8] = wdata_buf[beat][8*b +: 8];
      end
    end
    w_valid_i <= 1'b0;
    w_last_i  <= 1'b0;
    waited = 0;
    while (exp_b_id.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > max_wait) timeout_abort("B response");
    end
  endtask

  // AR, queue the expected beats, wait until the monitor has seen them all
  task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input int len, input logic [1:0] burst);
    int waited;
    int beat;
    ar_id_i    <= id;
    ar_addr_i  <= addr;
    ar_len_i   <= LEN_W'(len);
    ar_burst_i <= burst;
    ar_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > max_wait) timeout_abort("AR handshake");
    end while (!ar_ready_o);
    ar_valid_i <= 1'b0;
    for (beat = 0; beat <= len; beat++) begin
      exp_r_data.push_back(model_mem[word_index(ref_beat_addr(addr, len, burst, beat))]);
      exp_r_last.push_back(beat == len);
      exp_r_id.push_back(id);
    end
    waited = 0;
    while (exp_r_data.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > max_wait) timeout_abort("R beats");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // clock, ready drivers and monitors
  ////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : ready_driver
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (bp_en) begin
        r_ready_i <= 1'($urandom_range(0, 1));
        b_ready_i <= ($urandom_range(0, 2) != 0);
      end else begin
        r_ready_i <= 1'b1;
        b_ready_i <= 1'b1;
      end
    end
  end

  // R beats against the queued model data, plus stability while stalled
  initial begin : r_monitor
    logic              held;
    logic [DATA_W-1:0] held_data;
    logic [DATA_W-1:0] exp_data;
    logic              exp_last;
    logic [ID_W-1:0]   exp_id;
    held = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        if (held && !r_valid_o) begin
          proto_errs++;
          $display("r_valid_o dropped at %0t before the beat was taken", $time);
        end
        if (held && r_valid_o && r_data_o !== held_data) begin
          data_errs++;
          $display("error at %0t: R data changed while stalled", $time);
        end
        if (r_valid_o && r_ready_i) begin
          if (exp_r_data.size() == 0) begin
            proto_errs++;
            $display("an R beat arrived at %0t with none expected", $time);
          end else begin
            exp_data = exp_r_data.pop_front();
            exp_last = exp_r_last.pop_front();
            exp_id   = exp_r_id.pop_front();
            if (r_data_o !== exp_data) begin
              data_errs++;
              $display("error at %0t: R data %h, expected %h", $time, r_data_o, exp_data);
            end
            if (r_last_o !== exp_last) begin
              data_errs++;
              $display("error at %0t: R last %b, expected %b", $time, r_last_o, exp_last);
            end
            if (r_id_o !== exp_id || r_resp_o !== RESP_OKAY) begin
              data_errs++;
              $display("error at %0t: R id %h resp %h, expected %h", $time, r_id_o,
                       r_resp_o, exp_id);
            end
          end
        end
        held      = r_valid_o && !r_ready_i;
        held_data = r_data_o;
      end
    end
  end

  initial begin : b_monitor
    logic [ID_W-1:0] exp_id;
    forever begin
      @(posedge clk_i);
      if (rst_ni && b_valid_o && b_ready_i) begin
        if (exp_b_id.size() == 0) begin
          proto_errs++;
          $display("a B response arrived at %0t with none expected", $time);
        end else begin
          exp_id = exp_b_id.pop_front();
          if (b_id_o !== exp_id || b_resp_o !== RESP_OKAY) begin
            data_errs++;
            $display("error at %0t: B id %h resp %h, expected %h", $time, b_id_o,
                     b_resp_o, exp_id);
          end
        end
      end
    end
  end

  // last resort if the whole run stalls
  initial begin : watchdog
    repeat (200000) @(posedge clk_i);
    $display("the run did not finish within 200000 cycles");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin : main
    int                i;
    int                k;
    int                n;
    int                len;
    int                lens [4];
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] low;
    void'($urandom(32'ha8329718));
    rst_ni     = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_burst_i = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    w_valid_i  = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_burst_i = '0;
    ar_valid_i = 1'b0;
    lens       = '{1, 3, 7, 15};
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet outputs with no traffic
    repeat (3) begin
      @(posedge clk_i);
      if (aw_ready_o || ar_ready_o || w_ready_o || r_valid_o || b_valid_o) begin
        proto_errs++;
        $display("error at %0t: handshake outputs active with no traffic", $time);
      end
    end

    // fill every word so that all reads hit known data
    for (i = 0; i < MEM_WORDS / 16; i++) begin
      for (k = 0; k < 16; k++) begin
        wdata_buf[k] = fill_pattern(i * 16 + k);
        wstrb_buf[k] = '1;
      end
      write_burst(ID_W'(i), ADDR_W'(i * 16 * STRB_W), 15, INCR);
    end

    // INCR write then read back, random length and start
    for (n = 0; n < 12; n++) begin
      len  = $urandom_range(0, 15);
      addr = ADDR_W'($urandom());
      load_random_beats(len, 1'b0);
      write_burst(ID_W'(n), addr, len, INCR);
      read_burst(ID_W'(n + 1), addr, len, INCR);
    end

    // WRAP from mid-window, read back linearly and as the same WRAP
    for (n = 0; n < 4; n++) begin
      len  = lens[n];
      low  = ADDR_W'(32'h0400 + n * 32'h0100);
      addr = low + ADDR_W'((len + 1) / 2 * STRB_W);
      for (k = 0; k <= len; k++) begin
        wdata_buf[k] = 32'h5700_0000 | (32'(n) << 16) | 32'(k);
        wstrb_buf[k] = '1;
      end
      write_burst(4'h5, addr, len, WRAP);
      read_burst(4'h6, low, len, INCR);
      read_burst(4'h7, addr, len, WRAP);
    end

    // FIXED with partial strobes merges into one word, neighbours untouched
    addr = 16'h0802;
    load_random_beats(3, 1'b1);
    write_burst(4'h8, addr, 3, FIXED);
    read_burst(4'h9, addr, 0, FIXED);
    read_burst(4'ha, addr, 3, FIXED);
    read_burst(4'hb, 16'h07fc, 2, INCR);

    // read and write in flight together on disjoint ranges
    load_random_beats(15, 1'b0);
    fork
      write_burst(4'hc, 16'h1000, 15, INCR);
      read_burst(4'hd, 16'h0600, 15, INCR);
    join
    read_burst(4'he, 16'h1000, 15, INCR);

    // random back-pressure on R and B
    bp_en = 1'b1;
    for (n = 0; n < 10; n++) begin
      addr = ADDR_W'($urandom()) & 16'h0ffc;
      if (n % 2 == 0) begin
        len = lens[n % 4];
        load_random_beats(len, 1'b0);
        write_burst(ID_W'(n), addr, len, WRAP);
        read_burst(ID_W'(n + 3), addr, len, WRAP);
      end else begin
        len = $urandom_range(0, 15);
        load_random_beats(len, 1'b1);
        write_burst(ID_W'(n), addr, len, INCR);
        read_burst(ID_W'(n + 3), addr, len, INCR);
      end
    end
    bp_en = 1'b0;

    repeat (4) @(posedge clk_i);
    if (exp_r_data.size() != 0 || exp_b_id.size() != 0) begin
      proto_errs++;
      $display("responses still outstanding at the end of the run");
    end
    $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
logic/axi_sram_pkg.sv
logic/mem_port_if.sv
logic/sp_sram.sv
logic/mem_port_arbiter.sv
logic/axi_rd_engine.sv
logic/axi_wr_engine.sv
logic/axi_sram_top.sv
dv/tb_axi_sram.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the AXI SRAM slave testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module tb_axi_sram -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
